// File: Bender.yml
package:
  name: mmu_tlb

sources:
  - logic/mmuPkg.sv
  - logic/mmuControlRegs.sv
  - logic/tlbWayArrays.sv
  - logic/tlbLookup.sv
  - logic/tlbReplace.sv
  - logic/mmuTlb.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/mmuTlbTb.sv

// File: dv/tlbModel.svh
// TLB reference model
// per-set ordered entry lists, generation, enable state
// set hash, insertion, promotion and the expected response function
`ifndef TLB_MODEL_SVH
`define TLB_MODEL_SVH

localparam int modelSets = 1 << setBits;

logic [pageNumWidth-1:0] modelVpn   [modelSets][numWays];
logic [pageNumWidth-1:0] modelPpn   [modelSets][numWays];
logic [genWidth-1:0]     modelGen   [modelSets][numWays];
logic                    modelValid [modelSets][numWays];
logic [genWidth-1:0]     modelCurGen;
logic                    modelEnable;

function automatic void modelReset();
	for (int s = 0; s < modelSets; s++)
		for (int w = 0; w < numWays; w++)
			modelValid[s][w] = 1'b0;
	modelCurGen = '0;
	modelEnable = 1'b0;
endfunction

// XOR of the two lowest groups of the page number
function automatic int modelIndex(input logic [pageNumWidth-1:0] vpn);
	logic [setBits-1:0] lowGroup;
	logic [setBits-1:0] nextGroup;
	lowGroup  = vpn[setBits-1:0];
	nextGroup = vpn[2*setBits-1:setBits];
	return int'(lowGroup ^ nextGroup);
endfunction

// moves list entry 'way' to the front, entries before it slide back one
function automatic void modelMoveFront(input int s, input int way);
	logic [pageNumWidth-1:0] keepVpn;
	logic [pageNumWidth-1:0] keepPpn;
	logic [genWidth-1:0]     keepGen;
	logic                    keepValid;
	keepVpn   = modelVpn[s][way];
	keepPpn   = modelPpn[s][way];
	keepGen   = modelGen[s][way];
	keepValid = modelValid[s][way];
	for (int w = way; w > 0; w--)
	begin
		modelVpn[s][w]   = modelVpn[s][w-1];
		modelPpn[s][w]   = modelPpn[s][w-1];
		modelGen[s][w]   = modelGen[s][w-1];
		modelValid[s][w] = modelValid[s][w-1];
	end
	modelVpn[s][0]   = keepVpn;
	modelPpn[s][0]   = keepPpn;
	modelGen[s][0]   = keepGen;
	modelValid[s][0] = keepValid;
endfunction

// new entry goes first, the last one drops off
function automatic void modelInsert(input logic [pageNumWidth-1:0] vpn,
	input logic [pageNumWidth-1:0] ppn);
	int s;
	s = modelIndex(vpn);
	modelMoveFront(s, numWays - 1);
	modelVpn[s][0]   = vpn;
	modelPpn[s][0]   = ppn;
	modelGen[s][0]   = modelCurGen;
	modelValid[s][0] = 1'b1;
endfunction

function automatic int modelFindWay(input logic [pageNumWidth-1:0] vpn);
	int s;
	s = modelIndex(vpn);
	for (int w = 0; w < numWays; w++)
		if (modelValid[s][w] && modelGen[s][w] == modelCurGen && modelVpn[s][w] == vpn)
			return w;
	return -1;
endfunction

// expected response of one request, and the state change it causes
function automatic void modelRespond(input tlbOp_e op, input logic [vaddrWidth-1:0] addr,
	input logic [pageNumWidth-1:0] ppn, output logic [vaddrWidth-1:0] expAddr,
	output logic [15:0] expExc);
	logic [pageNumWidth-1:0] vpn;
	logic [3:0]              top;
	logic                    phys;
	int                      way;
	int                      s;
	vpn     = addr[vaddrWidth-1:pageBits];
	top     = addr[vaddrWidth-1 -: 4];
	phys    = (top == physWindowC) || (top == physWindowV);
	expAddr = addr;
	expExc  = excNone;
	if (modelEnable && !phys && (op == opLoad || op == opStore))
	begin
		way = modelFindWay(vpn);
		if (way >= 0)
		begin
			s       = modelIndex(vpn);
			expAddr = {modelPpn[s][way], addr[pageBits-1:0]};
			if (expAddr[vaddrWidth-1 -: 4] == 4'h0)
				expAddr[vaddrWidth-1 -: 4] = physTopNibble;
			modelMoveFront(s, way);
		end
		else
		begin
			expAddr = {missRedirectPage, addr[pageBits-1:0]};
			expExc  = excTlbMiss;
		end
	end
	else if (phys)
		expAddr[vaddrWidth-1 -: 4] = physTopNibble;
	if (op == opLdtlb)
		modelInsert(vpn, ppn);
	if (op == opInvtlb)
		modelCurGen = modelCurGen + 1'b1;
endfunction

`endif

// File: dv/mmuTlbTb.sv
// testbench for the four-way TLB
// clock and reset, LCG stimulus, request tasks, response compare process
// per-test and closing reports
`timescale 1ns/100ps
`default_nettype none

module mmuTlbTb;
	import mmuPkg::*;

	localparam int setBits    = 6;
	localparam int drainLimit = 40;

	logic                    clock;
	logic                    reset;
	logic                    hold;
	tlbOp_e                  reqOp;
	logic [vaddrWidth-1:0]   reqAddr;
	logic [15:0]             reqSeq;
	logic [pageNumWidth-1:0] reqPpn;
	logic                    cfgWrite;
	logic                    cfgEnable;
	tlbOp_e                  rspOp;
	logic [vaddrWidth-1:0]   rspAddr;
	logic [15:0]             rspSeq;
	logic [15:0]             rspExc;

	// expected responses, oldest first
	int                    expDue  [$];
	tlbOp_e                expOp   [$];
	logic [vaddrWidth-1:0] expAddr [$];
	logic [15:0]           expSeq  [$];
	logic [15:0]           expExc  [$];

	int          unheldEdges;
	int          checkCount;
	int          errorCount;
	int          testChecks;
	int          testErrors;
	logic [15:0] seqNext;
	logic [31:0] lcgState;

	`include "tlbModel.svh"

	mmuTlb #(.setBits(setBits)) i_mmuTlb
	(
		.clock(clock), .reset(reset), .hold(hold),
		.reqOp(reqOp), .reqAddr(reqAddr), .reqSeq(reqSeq), .reqPpn(reqPpn),
		.cfgWrite(cfgWrite), .cfgEnable(cfgEnable),
		.rspOp(rspOp), .rspAddr(rspAddr), .rspSeq(rspSeq), .rspExc(rspExc)
	);

	initial
	begin
		clock = 1'b0;
		forever
			#4 clock = ~clock;
	end

	// counts only edges the pipeline actually advances on
	always @(posedge clock)
	begin
		if (!hold)
			unheldEdges <= unheldEdges + 1;
	end

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// top nibble kept below 8, so never in the physical window
	function automatic logic [pageNumWidth-1:0] randomPage();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = nextRand();
		lo = nextRand();
		return {1'b0, hi[2:0], lo};
	endfunction

	function automatic logic [pageNumWidth-1:0] pageInSet(input logic [setBits-1:0] idx);
		logic [pageNumWidth-1:0] page;
		page = randomPage();
		page[setBits-1:0] = idx ^ page[2*setBits-1:setBits];
		return page;
	endfunction

	function automatic logic [vaddrWidth-1:0] pageAddr(input logic [pageNumWidth-1:0] page);
		logic [31:0] r;
		r = nextRand();
		return {page, r[pageBits-1:0]};
	endfunction

	task automatic reportMismatch(input string name, input logic [vaddrWidth-1:0] expValue,
		input logic [vaddrWidth-1:0] gotValue);
		$display("error at %0t ns: %s expected %h got %h", $time, name, expValue, gotValue);
		errorCount++;
	endtask

	// response compare, once per cycle where outputs are stable
	always @(negedge clock)
	begin
		while (expDue.size() > 0 && expDue[0] == unheldEdges)
		begin
			checkCount++;
			if (rspOp !== expOp[0])
				reportMismatch("rspOp", expOp[0], rspOp);
			if (rspAddr !== expAddr[0])
				reportMismatch("rspAddr", expAddr[0], rspAddr);
			if (rspSeq !== expSeq[0])
				reportMismatch("rspSeq", expSeq[0], rspSeq);
			if (rspExc !== expExc[0])
				reportMismatch("rspExc", expExc[0], rspExc);
			void'(expDue.pop_front());
			void'(expOp.pop_front());
			void'(expAddr.pop_front());
			void'(expSeq.pop_front());
			void'(expExc.pop_front());
		end
	end

	task automatic driveRequest(input tlbOp_e op, input logic [vaddrWidth-1:0] addr,
		input logic [pageNumWidth-1:0] ppn);
		logic [vaddrWidth-1:0] eAddr;
		logic [15:0]           eExc;
		@(posedge clock);
		#1;
		reqOp   = op;
		reqAddr = addr;
		reqPpn  = ppn;
		reqSeq  = seqNext;
		modelRespond(op, addr, ppn, eAddr, eExc);
		expDue.push_back(unheldEdges + 2);
		expOp.push_back(op);
		expAddr.push_back(eAddr);
		expSeq.push_back(seqNext);
		expExc.push_back(eExc);
		seqNext++;
	endtask

	// request followed by three idle cycles
	task automatic sendRequest(input tlbOp_e op, input logic [vaddrWidth-1:0] addr,
		input logic [pageNumWidth-1:0] ppn);
		driveRequest(op, addr, ppn);
		@(posedge clock);
		#1;
		reqOp = opIdle;
		repeat (2) @(posedge clock);
	endtask

	task automatic setEnable(input logic value);
		@(posedge clock);
		#1;
		cfgWrite  = 1'b1;
		cfgEnable = value;
		@(posedge clock);
		#1;
		cfgWrite    = 1'b0;
		modelEnable = value;
	endtask

	task automatic waitDrain();
		int waited;
		waited = 0;
		while (expDue.size() > 0 && waited < drainLimit)
		begin
			@(posedge clock);
			waited++;
		end
		if (expDue.size() > 0)
		begin
			$display("timeout: %0d responses never arrived", expDue.size());
			errorCount++;
			expDue.delete();
			expOp.delete();
			expAddr.delete();
			expSeq.delete();
			expExc.delete();
		end
	endtask

	task automatic beginTest();
		testChecks = checkCount;
		testErrors = errorCount;
	endtask

	task automatic endTest(input string name);
		waitDrain();
		$display("test %s: %0d checks, %0d errors", name, checkCount - testChecks,
			errorCount - testErrors);
	endtask

	initial
	begin
		logic [pageNumWidth-1:0] pages [$];
		logic [pageNumWidth-1:0] setPages [5];
		logic [pageNumWidth-1:0] ppn;
		logic [vaddrWidth-1:0]   addr;
		logic [setBits-1:0]      idx;
		logic [31:0]             r;
		tlbOp_e                  snapOp;
		logic [vaddrWidth-1:0]   snapAddr;
		logic [15:0]             snapSeq;
		logic [15:0]             snapExc;

		reset       = 1'b1;
		hold        = 1'b0;
		reqOp       = opIdle;
		reqAddr     = '0;
		reqSeq      = '0;
		reqPpn      = '0;
		cfgWrite    = 1'b0;
		cfgEnable   = 1'b0;
		unheldEdges = 0;
		checkCount  = 0;
		errorCount  = 0;
		seqNext     = 16'h0001;
		lcgState    = 32'hd4145136;
		modelReset();
		repeat (4) @(posedge clock);
		#1;
		reset = 1'b0;

		// MMU off, window addresses get the C nibble
		beginTest();
		for (int i = 0; i < 8; i++)
		begin
			r    = nextRand();
			addr = {r[15:0], nextRand()};
			if (i % 4 == 0)
				addr[vaddrWidth-1 -: 4] = 4'hC;
			if (i % 4 == 1)
				addr[vaddrWidth-1 -: 4] = 4'hD;
			sendRequest((i % 2 == 0) ? opLoad : opStore, addr, '0);
		end
		endTest("disabled");

		beginTest();
		setEnable(1'b1);
		for (int i = 0; i < 4; i++)
			sendRequest(opLoad, pageAddr(randomPage()), '0);
		endTest("miss");

		// even entries get a ppn with top nibble 0
		beginTest();
		for (int i = 0; i < 6; i++)
		begin
			pages.push_back(randomPage());
			ppn = randomPage();
			if (i % 2 == 0)
				ppn[pageNumWidth-1 -: 4] = 4'h0;
			sendRequest(opLdtlb, pageAddr(pages[i]), ppn);
		end
		for (int i = 0; i < 6; i++)
			sendRequest((i % 2 == 0) ? opLoad : opStore, pageAddr(pages[i]), '0);
		endTest("hit");

		// five inserts into one set, then a promoted entry surviving an insert
		beginTest();
		r   = nextRand();
		idx = r[setBits-1:0];
		for (int i = 0; i < 5; i++)
		begin
			setPages[i] = pageInSet(idx);
			sendRequest(opLdtlb, pageAddr(setPages[i]), randomPage());
		end
		for (int i = 0; i < 5; i++)
			sendRequest(opLoad, pageAddr(setPages[i]), '0);
		idx = idx ^ 1'b1;
		for (int i = 0; i < 5; i++)
			setPages[i] = pageInSet(idx);
		for (int i = 0; i < 4; i++)
			sendRequest(opLdtlb, pageAddr(setPages[i]), randomPage());
		sendRequest(opLoad, pageAddr(setPages[0]), '0);
		sendRequest(opLdtlb, pageAddr(setPages[4]), randomPage());
		for (int i = 0; i < 5; i++)
			sendRequest(opLoad, pageAddr(setPages[i]), '0);
		endTest("replacement");

		beginTest();
		sendRequest(opInvtlb, pageAddr(randomPage()), '0);
		for (int i = 0; i < 6; i++)
			sendRequest(opLoad, pageAddr(pages[i]), '0);
		sendRequest(opLdtlb, pageAddr(pages[0]), randomPage());
		sendRequest(opLoad, pageAddr(pages[0]), '0);
		endTest("invalidate");

		// request in stage 1 while hold is high for five edges
		beginTest();
		driveRequest(opLoad, pageAddr(pages[0]), '0);
		@(posedge clock);
		#1;
		reqOp    = opIdle;
		hold     = 1'b1;
		snapOp   = rspOp;
		snapAddr = rspAddr;
		snapSeq  = rspSeq;
		snapExc  = rspExc;
		repeat (5)
		begin
			@(negedge clock);
			checkCount++;
			if (rspOp !== snapOp)
				reportMismatch("rspOp", snapOp, rspOp);
			if (rspAddr !== snapAddr)
				reportMismatch("rspAddr", snapAddr, rspAddr);
			if (rspSeq !== snapSeq)
				reportMismatch("rspSeq", snapSeq, rspSeq);
			if (rspExc !== snapExc)
				reportMismatch("rspExc", snapExc, rspExc);
		end
		@(posedge clock);
		#1;
		hold = 1'b0;
		endTest("hold");

		$display("total: %0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+dv
logic/mmuPkg.sv
logic/mmuControlRegs.sv
logic/tlbWayArrays.sv
logic/tlbLookup.sv
logic/tlbReplace.sv
logic/mmuTlb.sv
dv/mmuTlbTb.sv

// File: logic/mmuControlRegs.sv
// MMU control register block
// enable bit and the TLB generation counter
`timescale 1ns/100ps
`default_nettype none

module mmuControlRegs
(
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          hold,
	input  logic                          cfgWrite,
	input  logic                          cfgEnable,
	input  logic                          invalidate,
	output logic                          mmuEnable,
	output logic [mmuPkg::genWidth-1:0]   curGen
);

	// enable level, loaded by the config strobe
	always_ff @(posedge clock)
	begin
		if (reset)
			mmuEnable <= 1'b0;
		else if (cfgWrite)
			mmuEnable <= cfgEnable;
	end

	// bumping the generation retires every stored entry at once
	always_ff @(posedge clock)
	begin
		if (reset)
			curGen <= '0;
		else if (invalidate && !hold)
			curGen <= curGen + 1'b1;
	end

endmodule

`default_nettype wire

// File: logic/mmuPkg.sv
// shared MMU definitions
// request operation codes, address and generation widths
// stored TLB entry layout, exception codes, miss redirect page
`default_nettype none

package mmuPkg;

	// request operations
	typedef enum logic [2:0]
	{
		opIdle   = 3'd0,
		opLoad   = 3'd1,
		opStore  = 3'd2,
		opLdtlb  = 3'd3,
		opInvtlb = 3'd4
	} tlbOp_e;

	localparam int vaddrWidth   = 48;
	localparam int pageBits     = 12;
	localparam int pageNumWidth = 36;
	localparam int genWidth     = 8;

	// associativity, fixed
	localparam int numWays = 4;

	// one stored translation, 80 bits
	typedef struct packed
	{
		logic [genWidth-1:0]     gen;
		logic [pageNumWidth-1:0] vpn;
		logic [pageNumWidth-1:0] ppn;
	} tlbEntry_t;

	localparam logic [15:0] excNone    = 16'h0000;
	localparam logic [15:0] excTlbMiss = 16'hA001;

	// page substituted when a translated access misses
	localparam logic [pageNumWidth-1:0] missRedirectPage = 36'h010;

	// top nibbles of the physical address window
	localparam logic [3:0] physWindowC = 4'hC;
	localparam logic [3:0] physWindowV = 4'hD;

	// forced into the top nibble of physical results
	localparam logic [3:0] physTopNibble = 4'hC;

endpackage

`default_nettype wire

// File: logic/mmuTlb.sv
// four-way set-associative TLB, top level
// request registers, invalidate decode, submodule instances
`timescale 1ns/100ps
`default_nettype none

module mmuTlb
#(
	parameter int setBits = 6
)
(
	input  logic                              clock,
	input  logic                              reset,
	input  logic                              hold,
	input  mmuPkg::tlbOp_e                    reqOp,
	input  logic [mmuPkg::vaddrWidth-1:0]     reqAddr,
	input  logic [15:0]                       reqSeq,
	input  logic [mmuPkg::pageNumWidth-1:0]   reqPpn,
	input  logic                              cfgWrite,
	input  logic                              cfgEnable,
	output mmuPkg::tlbOp_e                    rspOp,
	output logic [mmuPkg::vaddrWidth-1:0]     rspAddr,
	output logic [15:0]                       rspSeq,
	output logic [15:0]                       rspExc
);
	import mmuPkg::*;

	tlbOp_e                  stageOp;
	logic [vaddrWidth-1:0]   stageAddr;
	logic [15:0]             stageSeq;
	logic [pageNumWidth-1:0] stagePpn;
	logic                    invalidate;
	logic                    mmuEnable;
	logic [genWidth-1:0]     curGen;
	tlbEntry_t               readWays [numWays];
	tlbEntry_t               newWays [numWays];
	logic [numWays-1:0]      readValid;
	logic [numWays-1:0]      hitWay;
	logic                    lookupUpdate;
	logic                    wayWrite;

	// stage 1 request, lines up with the way read data
	always_ff @(posedge clock)
	begin
		if (reset)
			stageOp <= opIdle;
		else if (!hold)
			stageOp <= reqOp;
	end

	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			stageAddr <= reqAddr;
			stageSeq  <= reqSeq;
			stagePpn  <= reqPpn;
		end
	end

	assign invalidate = (stageOp == opInvtlb);

	mmuControlRegs i_mmuControlRegs
	(
		.clock(clock), .reset(reset), .hold(hold),
		.cfgWrite(cfgWrite), .cfgEnable(cfgEnable), .invalidate(invalidate),
		.mmuEnable(mmuEnable), .curGen(curGen)
	);

	tlbWayArrays #(.setBits(setBits)) i_tlbWayArrays
	(
		.clock(clock), .reset(reset), .hold(hold),
		.lookupAddr(reqAddr), .wayWrite(wayWrite), .newWays(newWays),
		.readWays(readWays), .readValid(readValid)
	);

	tlbLookup #(.setBits(setBits)) i_tlbLookup
	(
		.clock(clock), .reset(reset), .hold(hold),
		.stageOp(stageOp), .stageAddr(stageAddr), .stageSeq(stageSeq),
		.readWays(readWays), .readValid(readValid),
		.mmuEnable(mmuEnable), .curGen(curGen),
		.hitWay(hitWay), .lookupUpdate(lookupUpdate),
		.rspOp(rspOp), .rspAddr(rspAddr), .rspSeq(rspSeq), .rspExc(rspExc)
	);

	tlbReplace #(.setBits(setBits)) i_tlbReplace
	(
		.stageOp(stageOp), .stageAddr(stageAddr), .stagePpn(stagePpn),
		.curGen(curGen), .readWays(readWays), .readValid(readValid),
		.hitWay(hitWay), .lookupUpdate(lookupUpdate), .hold(hold),
		.wayWrite(wayWrite), .newWays(newWays)
	);

endmodule

`default_nettype wire

// File: logic/tlbLookup.sv
// TLB compare stage
// way match, physical address formation, window bypass, miss redirect
// output registers for the response
`timescale 1ns/100ps
`default_nettype none

module tlbLookup
#(
	parameter int setBits = 6
)
(
	input  logic                              clock,
	input  logic                              reset,
	input  logic                              hold,
	input  mmuPkg::tlbOp_e                    stageOp,
	input  logic [mmuPkg::vaddrWidth-1:0]     stageAddr,
	input  logic [15:0]                       stageSeq,
	input  mmuPkg::tlbEntry_t                 readWays [mmuPkg::numWays],
	input  logic [mmuPkg::numWays-1:0]        readValid,
	input  logic                              mmuEnable,
	input  logic [mmuPkg::genWidth-1:0]       curGen,
	output logic [mmuPkg::numWays-1:0]        hitWay,
	output logic                              lookupUpdate,
	output mmuPkg::tlbOp_e                    rspOp,
	output logic [mmuPkg::vaddrWidth-1:0]     rspAddr,
	output logic [15:0]                       rspSeq,
	output logic [15:0]                       rspExc
);
	import mmuPkg::*;

	logic [pageNumWidth-1:0] stagePage;
	logic [pageNumWidth-1:0] hitPpn;
	logic [numWays-1:0]      hitVec;
	logic [3:0]              topNibble;
	logic                    isPhys;
	logic                    translate;
	logic [vaddrWidth-1:0]   outAddr;
	logic [15:0]             outExc;

	assign stagePage = stageAddr[vaddrWidth-1:pageBits];
	assign topNibble = stageAddr[vaddrWidth-1 -: 4];
	assign isPhys    = (topNibble == physWindowC) || (topNibble == physWindowV);
	assign translate = mmuEnable && !isPhys && (stageOp == opLoad || stageOp == opStore);

	// the set index already fixes the low group, so only the high part is compared
	always_comb
	begin
		for (int w = 0; w < numWays; w++)
			hitVec[w] = readValid[w] && (readWays[w].gen == curGen) &&
				(readWays[w].vpn[pageNumWidth-1:setBits] ==
				stagePage[pageNumWidth-1:setBits]);
	end

	// lowest hitting way wins
	assign hitWay       = hitVec & (~hitVec + 1'b1);
	assign lookupUpdate = translate && (hitVec != '0);

	always_comb
	begin
		hitPpn = '0;
		for (int w = 0; w < numWays; w++)
		begin
			if (hitWay[w])
				hitPpn = readWays[w].ppn;
		end
	end

	always_comb
	begin
		outAddr = stageAddr;
		outExc  = excNone;
		if (translate)
		begin
			if (hitVec != '0)
			begin
				outAddr = {hitPpn, stageAddr[pageBits-1:0]};
				if (outAddr[vaddrWidth-1 -: 4] == 4'h0)
					outAddr[vaddrWidth-1 -: 4] = physTopNibble;
			end
			else
			begin
				// miss goes to the redirect page, offset kept
				outAddr = {missRedirectPage, stageAddr[pageBits-1:0]};
				outExc  = excTlbMiss;
			end
		end
		else if (isPhys)
			outAddr[vaddrWidth-1 -: 4] = physTopNibble;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			rspOp  <= opIdle;
			rspExc <= excNone;
		end
		else if (!hold)
		begin
			rspOp  <= stageOp;
			rspExc <= outExc;
		end
	end

	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			rspAddr <= outAddr;
			rspSeq  <= stageSeq;
		end
	end

endmodule

`default_nettype wire

// File: logic/tlbReplace.sv
// TLB replacement
// new set contents for LDTLB insertion and hit promotion, plus write enable
`timescale 1ns/100ps
`default_nettype none

module tlbReplace
#(
	parameter int setBits = 6
)
(
	input  mmuPkg::tlbOp_e                    stageOp,
	input  logic [mmuPkg::vaddrWidth-1:0]     stageAddr,
	input  logic [mmuPkg::pageNumWidth-1:0]   stagePpn,
	input  logic [mmuPkg::genWidth-1:0]       curGen,
	input  mmuPkg::tlbEntry_t                 readWays [mmuPkg::numWays],
	input  logic [mmuPkg::numWays-1:0]        readValid,
	input  logic [mmuPkg::numWays-1:0]        hitWay,
	input  logic                              lookupUpdate,
	input  logic                              hold,
	output logic                              wayWrite,
	output mmuPkg::tlbEntry_t                 newWays [mmuPkg::numWays]
);
	import mmuPkg::*;

	localparam logic [pageNumWidth-1:0] lowGroupMask =
		{{(pageNumWidth-setBits){1'b0}}, {setBits{1'b1}}};

	logic [pageNumWidth-1:0] stageVpn;
	tlbEntry_t               fillEntry;
	tlbEntry_t               loadEntry;
	tlbEntry_t               hitEntry;
	tlbEntry_t               curWays [numWays];

	assign stageVpn = stageAddr[vaddrWidth-1:pageBits];

	// filler for never-loaded ways
	// it can only alias the page loaded with it, which always sits in a lower way
	assign fillEntry = '{gen: curGen, vpn: stageVpn ^ lowGroupMask, ppn: '0};
	assign loadEntry = '{gen: curGen, vpn: stageVpn, ppn: stagePpn};

	always_comb
	begin
		hitEntry = readWays[0];
		for (int w = 0; w < numWays; w++)
		begin
			curWays[w] = readValid[w] ? readWays[w] : fillEntry;
			if (hitWay[w])
				hitEntry = readWays[w];
		end
	end

	always_comb
	begin
		wayWrite = 1'b0;
		newWays  = curWays;
		if (!hold && stageOp == opLdtlb)
		begin
			// new entry on top, way 3 falls out
			wayWrite   = 1'b1;
			newWays[0] = loadEntry;
			for (int w = 1; w < numWays; w++)
				newWays[w] = curWays[w-1];
		end
		else if (!hold && lookupUpdate && !hitWay[0])
		begin
			// hit moves up, the ways it passes slide down one
			wayWrite   = 1'b1;
			newWays[0] = hitEntry;
			for (int w = 1; w < numWays; w++)
			begin
				if (|(hitWay >> w))
					newWays[w] = curWays[w-1];
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/tlbWayArrays.sv
// TLB way storage
// four way memories and per-set valid bits
// hashed set index, registered reads, write at the held index
`timescale 1ns/100ps
`default_nettype none

module tlbWayArrays
#(
	parameter int setBits = 6
)
(
	input  logic                              clock,
	input  logic                              reset,
	input  logic                              hold,
	input  logic [mmuPkg::vaddrWidth-1:0]     lookupAddr,
	input  logic                              wayWrite,
	input  mmuPkg::tlbEntry_t                 newWays [mmuPkg::numWays],
	output mmuPkg::tlbEntry_t                 readWays [mmuPkg::numWays],
	output logic [mmuPkg::numWays-1:0]        readValid
);
	import mmuPkg::*;

	localparam int numSets = 1 << setBits;

	logic [pageNumWidth-1:0] lookupPage;
	logic [setBits-1:0]      readIndex;
	logic [setBits-1:0]      heldIndex;
	logic [numWays-1:0]      validBits [numSets];

	// fold the two lowest groups of the page number
	assign lookupPage = lookupAddr[vaddrWidth-1:pageBits];
	assign readIndex  = lookupPage[setBits-1:0] ^ lookupPage[2*setBits-1:setBits];

	// index kept for the write one cycle later
	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			heldIndex <= readIndex;
			readValid <= validBits[readIndex];
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int s = 0; s < numSets; s++)
				validBits[s] <= '0;
		end
		else if (wayWrite)
		begin
			// all four ways are rewritten together
			validBits[heldIndex] <= '1;
		end
	end

	// one memory per way, all on the same index
	for (genvar w = 0; w < numWays; w++)
	begin : gWay
		tlbEntry_t wayMem [numSets];

		always_ff @(posedge clock)
		begin
			if (wayWrite)
				wayMem[heldIndex] <= newWays[w];
			if (!hold)
				readWays[w] <= wayMem[readIndex];
		end
	end

endmodule

`default_nettype wire
